//--- tb.f
+incdir+design
design/irq_pkg.sv
design/exc_ctrl_if.sv
design/irq_arbiter.sv
design/exc_controller.sv
design/trap_sequencer.sv
design/irq_subsys_top.sv
verif/irq_subsys_assert.sv
verif/irq_subsys_tb.sv

//--- verif/irq_subsys_tb.sv
`timescale 1ns/1ns

`include "irq_defines.svh"

module irq_subsys_tb
  import irq_pkg::*;
();

  logic                 clk;
  logic                 rst_n;
  logic [`IRQ_NUM-1:0]  irq_lines;
  logic [`IRQ_NUM-1:0]  sec_mask;
  logic                 mret;
  logic                 ie_wr;
  logic                 m_ie_wdata;
  logic                 u_ie_wdata;
  logic                 enter_user;
  logic                 trap;
  logic [`IRQ_ID_W-1:0] trap_id;
  logic                 trap_sec;
  priv_lvl_e            priv_lvl;
  logic                 m_ie;

  // reference model state
  priv_lvl_e            mdl_priv;
  priv_lvl_e            mdl_ppriv;
  logic                 mdl_mie;
  logic                 mdl_mpie;
  logic                 mdl_uie;
  logic [`IRQ_NUM-1:0]  held;
  logic [`IRQ_NUM-1:0]  mask;
  integer               seed;
  int                   idx;
  logic [`IRQ_NUM-1:0]  v;

  // failure count of the bound handshake checker
  int unsigned          hs_errors;

  irq_subsys_top irq_subsys_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_lines_i  (irq_lines),
    .sec_mask_i   (sec_mask),
    .mret_i       (mret),
    .ie_wr_i      (ie_wr),
    .m_ie_wdata_i (m_ie_wdata),
    .u_ie_wdata_i (u_ie_wdata),
    .enter_user_i (enter_user),
    .trap_o       (trap),
    .trap_id_o    (trap_id),
    .trap_sec_o   (trap_sec),
    .priv_lvl_o   (priv_lvl),
    .m_ie_o       (m_ie)
  );

  assign hs_errors =
    irq_subsys_top_inst.exc_controller_inst.exc_controller_assert_inst.err_cnt;

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // stop at the first handshake assertion failure
  always @(posedge clk)
  begin
    assert (hs_errors == 0)
    else
    begin
      $display("handshake assertion failed at %0t ns", $time);
      $display("Simulation failed");
      $fatal(1, "handshake assertion");
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check(input bit ok, input string what);
    assert (ok)
    else
    begin
      $display("FAILED at %0t ns: %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // lowest index wins, searched upward
  function automatic int lowest_line(input logic [`IRQ_NUM-1:0] lines);
    int found;
    found = -1;
    for (int i = 0; i < `IRQ_NUM; i++)
    begin
      if (lines[i] && found < 0)
        found = i;
    end
    return found;
  endfunction

  // enable rule for one held line under the model's csr state
  function automatic bit trap_enabled(input bit sec);
    if (mdl_priv == PRIV_U)
      return mdl_uie | sec;
    else
      return mdl_mie;
  endfunction

  task automatic set_mask(input logic [`IRQ_NUM-1:0] m);
    @(posedge clk);
    mask = m;
    sec_mask <= m;
  endtask

  task automatic raise_lines(input logic [`IRQ_NUM-1:0] lines);
    @(posedge clk);
    held = lines;
    irq_lines <= lines;
  endtask

  task automatic write_ie(input logic mie, input logic uie);
    @(posedge clk);
    ie_wr      <= 1'b1;
    m_ie_wdata <= mie;
    u_ie_wdata <= uie;
    @(posedge clk);
    ie_wr <= 1'b0;
    mdl_mie = mie;
    mdl_uie = uie;
  endtask

  // no trap may show up for n cycles
  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(negedge clk);
      check(!trap, "trap_o raised while no trap was expected");
    end
  endtask

  // poll for trap_o, bounded at 12 cycles
  task automatic wait_for_trap();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 12 && !seen; i++)
    begin
      @(negedge clk);
      seen = trap;
    end
    assert (seen)
    else
    begin
      $display("no trap within timeout at %0t ns", $time);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  endtask

  // take one trap, check cause and csr state, then clear the line and return
  task automatic serve_trap();
    int exp_id;
    exp_id = lowest_line(held);
    wait_for_trap();
    check(trap_id == exp_id[`IRQ_ID_W-1:0],
          $sformatf("trap_id_o %0d, expected %0d", trap_id, exp_id));
    check(trap_sec == mask[exp_id],
          $sformatf("trap_sec_o %0b, expected %0b", trap_sec, mask[exp_id]));
    // model trap entry
    mdl_mpie  = mdl_mie;
    mdl_ppriv = mdl_priv;
    mdl_mie   = 1'b0;
    mdl_priv  = PRIV_M;
    check(priv_lvl == mdl_priv, "priv_lvl_o not machine mode after trap");
    check(m_ie == mdl_mie, "m_ie_o not cleared after trap");
    // device handler clears its line
    @(posedge clk);
    held[exp_id] = 1'b0;
    irq_lines <= held;
    repeat (2) @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    mdl_mie  = mdl_mpie;
    mdl_priv = mdl_ppriv;
    @(negedge clk);
    check(priv_lvl == mdl_priv,
          $sformatf("priv_lvl_o %0d after mret, expected %0d", priv_lvl, mdl_priv));
    check(m_ie == mdl_mie,
          $sformatf("m_ie_o %0b after mret, expected %0b", m_ie, mdl_mie));
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    seed       = 32'hc3f1ffc6;
    rst_n      = 1'b0;
    irq_lines  = '0;
    sec_mask   = '0;
    mret       = 1'b0;
    ie_wr      = 1'b0;
    m_ie_wdata = 1'b0;
    u_ie_wdata = 1'b0;
    enter_user = 1'b0;
    held       = '0;
    mask       = '0;
    mdl_priv   = PRIV_M;
    mdl_ppriv  = PRIV_M;
    mdl_mie    = 1'b0;
    mdl_mpie   = 1'b0;
    mdl_uie    = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check(!trap && priv_lvl == PRIV_M && !m_ie, "wrong state after reset");

    // machine mode with m_ie 0 masks everything
    set_mask($random(seed));
    raise_lines($random(seed) | 32'h1);
    expect_quiet(20);
    raise_lines('0);
    repeat (4) @(posedge clk);

    // priority across several held lines
    write_ie(1'b1, 1'b0);
    for (int r = 0; r < 4; r++)
    begin
      set_mask($random(seed));
      v = $random(seed) & $random(seed);
      if (v == '0)
        v = 32'h1 << (r * 7);
      raise_lines(v);
      while (held != '0)
        serve_trap();
    end

    // one-cycle pulse is gone before the ack
    for (int r = 0; r < 4; r++)
    begin
      idx = $unsigned($random(seed)) % `IRQ_NUM;
      @(posedge clk);
      irq_lines <= 32'h1 << idx;
      @(posedge clk);
      irq_lines <= '0;
      expect_quiet(20);
      idx = $unsigned($random(seed)) % `IRQ_NUM;
      raise_lines(32'h1 << idx);
      serve_trap();
    end

    // user mode with u_ie 0, only secure lines get through
    @(posedge clk);
    enter_user <= 1'b1;
    @(posedge clk);
    enter_user <= 1'b0;
    mdl_priv = PRIV_U;
    for (int r = 0; r < 8; r++)
    begin
      idx = $unsigned($random(seed)) % `IRQ_NUM;
      v = $random(seed);
      v[idx] = r[0];
      set_mask(v);
      raise_lines(32'h1 << idx);
      if (trap_enabled(mask[idx]))
        serve_trap();
      else
      begin
        expect_quiet(20);
        raise_lines('0);
        repeat (4) @(posedge clk);
      end
    end

    // user mode with u_ie 1, any line traps
    write_ie(1'b1, 1'b1);
    for (int r = 0; r < 4; r++)
    begin
      set_mask($random(seed));
      raise_lines(($random(seed) & $random(seed)) | (32'h1 << (r * 5 + 3)));
      while (held != '0)
        serve_trap();
    end

    @(posedge clk);
    if (hs_errors == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("handshake assertion failed at %0t ns", $time);
      $display("Simulation failed");
      $fatal(1, "handshake assertion");
    end
  end

endmodule

//--- verif/irq_subsys_assert.sv
`timescale 1ns/1ns

module irq_subsys_assert
  import irq_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  exc_state_e state_i,
  input  logic       ack_i,
  input  logic       done_i,
  input  logic       req_i
);

  // number of failed handshake assertions so far
  int unsigned err_cnt = 0;

  ////////////////////
  // handshake rules
  ////////////////////

  // done only closes a request that was acked and taken
  done_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> (state_i == EXC_ACK))
    else
    begin
      $error("done seen outside EXC_ACK");
      err_cnt++;
    end

  // the core acks only a request that is still pending
  ack_in_pending: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |-> (state_i == EXC_PENDING))
    else
    begin
      $error("ack seen outside EXC_PENDING");
      err_cnt++;
    end

  // a taken ack is closed by done exactly one cycle later
  done_after_taken: assert property (@(posedge clk) disable iff (!rst_n)
    (ack_i && req_i) |=> done_i)
    else
    begin
      $error("no done one cycle after a taken ack");
      err_cnt++;
    end

endmodule

// attach to every exception controller instance
bind exc_controller irq_subsys_assert exc_controller_assert_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .state_i (state_q),
  .ack_i   (ctrl.ack),
  .done_i  (ctrl.done),
  .req_i   (ctrl.irq_req)
);

//--- design/irq_subsys_top.sv
`timescale 1ns/1ns

`include "irq_defines.svh"

module irq_subsys_top
  import irq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`IRQ_NUM-1:0]  irq_lines_i,
  input  logic [`IRQ_NUM-1:0]  sec_mask_i,
  input  logic                 mret_i,
  input  logic                 ie_wr_i,
  input  logic                 m_ie_wdata_i,
  input  logic                 u_ie_wdata_i,
  input  logic                 enter_user_i,
  output logic                 trap_o,
  output logic [`IRQ_ID_W-1:0] trap_id_o,
  output logic                 trap_sec_o,
  output priv_lvl_e            priv_lvl_o,
  output logic                 m_ie_o
);

  // arbiter to exception controller
  logic                 arb_valid;
  logic [`IRQ_ID_W-1:0] arb_id;
  logic                 arb_sec;
  // user enable stays internal
  logic                 u_ie;

  // request / ack / done between controller and sequencer
  exc_ctrl_if ctrl_if ();

  ////////////////////
  // blocks
  ////////////////////

  irq_arbiter irq_arbiter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_lines_i (irq_lines_i),
    .sec_mask_i  (sec_mask_i),
    .irq_valid_o (arb_valid),
    .irq_id_o    (arb_id),
    .irq_sec_o   (arb_sec)
  );

  exc_controller exc_controller_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl_if.exc),
    .irq_i      (arb_valid),
    .irq_sec_i  (arb_sec),
    .irq_id_i   (arb_id),
    .m_ie_i     (m_ie_o),
    .u_ie_i     (u_ie),
    .priv_lvl_i (priv_lvl_o)
  );

  trap_sequencer trap_sequencer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl_if.core),
    .mret_i       (mret_i),
    .ie_wr_i      (ie_wr_i),
    .m_ie_wdata_i (m_ie_wdata_i),
    .u_ie_wdata_i (u_ie_wdata_i),
    .enter_user_i (enter_user_i),
    .priv_lvl_o   (priv_lvl_o),
    .m_ie_o       (m_ie_o),
    .u_ie_o       (u_ie),
    .trap_o       (trap_o),
    .trap_id_o    (trap_id_o),
    .trap_sec_o   (trap_sec_o)
  );

endmodule

//--- design/trap_sequencer.sv
`timescale 1ns/1ns

`include "irq_defines.svh"

module trap_sequencer
  import irq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  exc_ctrl_if.core             ctrl,
  input  logic                 mret_i,
  input  logic                 ie_wr_i,
  input  logic                 m_ie_wdata_i,
  input  logic                 u_ie_wdata_i,
  input  logic                 enter_user_i,
  output priv_lvl_e            priv_lvl_o,
  output logic                 m_ie_o,
  output logic                 u_ie_o,
  output logic                 trap_o,
  output logic [`IRQ_ID_W-1:0] trap_id_o,
  output logic                 trap_sec_o
);

  // drain counter, counts 0 .. ACK_DELAY-1
  localparam int unsigned          CNT_W    = $clog2(`ACK_DELAY + 1);
  localparam logic [CNT_W-1:0]     CNT_LAST = CNT_W'(`ACK_DELAY - 1);

  seq_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             taken;
  logic             enter;
  // previous-state copies, like mstatus.mpie and mpp
  logic             mpie_q;
  priv_lvl_e        ppriv_q;

  ////////////////////
  // handshake
  ////////////////////

  assign ctrl.ack = (state_q == SEQ_ACK);

  // request still high in the ack cycle, so it is ours
  assign taken = ctrl.ack & ctrl.irq_req;

  // trap entry cycle, done and trap go out together
  assign enter     = (state_q == SEQ_ENTER);
  assign ctrl.done = enter;
  assign trap_o    = enter;

  ////////////////////
  // fsm and csr state
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= SEQ_RUN;
      cnt_q      <= '0;
      priv_lvl_o <= PRIV_M;
      ppriv_q    <= PRIV_M;
      m_ie_o     <= 1'b0;
      u_ie_o     <= 1'b0;
      mpie_q     <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        SEQ_RUN:
        begin
          // csr writes from software
          if (ie_wr_i)
          begin
            m_ie_o <= m_ie_wdata_i;
            u_ie_o <= u_ie_wdata_i;
          end
          if (enter_user_i)
            priv_lvl_o <= PRIV_U;
          if (ctrl.irq_req)
          begin
            state_q <= SEQ_WAIT;
            cnt_q   <= '0;
          end
        end
        SEQ_WAIT:
        begin
          // pipeline drain, the ack goes out even if the request left
          if (cnt_q == CNT_LAST)
            state_q <= SEQ_ACK;
          else
            cnt_q <= cnt_q + 1'b1;
        end
        SEQ_ACK:
        begin
          if (taken)
          begin
            // push enable and privilege, go to machine mode
            mpie_q     <= m_ie_o;
            ppriv_q    <= priv_lvl_o;
            m_ie_o     <= 1'b0;
            priv_lvl_o <= PRIV_M;
            state_q    <= SEQ_ENTER;
          end
          else
          begin
            state_q <= SEQ_RUN;
          end
        end
        SEQ_ENTER:
        begin
          state_q <= SEQ_HANDLER;
        end
        SEQ_HANDLER:
        begin
          // m_ie is 0 here so no new request can show up
          if (mret_i)
          begin
            m_ie_o     <= mpie_q;
            priv_lvl_o <= ppriv_q;
            state_q    <= SEQ_RUN;
          end
        end
        default:
        begin
          state_q <= SEQ_RUN;
        end
      endcase
    end
  end

  // trap cause, visible from the entry cycle on
  always_ff @(posedge clk)
  begin
    if (taken)
    begin
      trap_id_o  <= ctrl.irq_id;
      trap_sec_o <= ctrl.irq_sec;
    end
  end

endmodule

//--- design/exc_controller.sv
`timescale 1ns/1ns

`include "irq_defines.svh"

module exc_controller
  import irq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  exc_ctrl_if.exc              ctrl,
  input  logic                 irq_i,
  input  logic                 irq_sec_i,
  input  logic [`IRQ_ID_W-1:0] irq_id_i,
  input  logic                 m_ie_i,
  input  logic                 u_ie_i,
  input  priv_lvl_e            priv_lvl_i
);

  exc_state_e           state_q;
  exc_state_e           state_d;
  logic                 irq_en_ext;
  logic                 irq_en_int;
  logic                 sample_en;
  logic                 irq_q;
  logic                 irq_sec_q;
  logic [`IRQ_ID_W-1:0] irq_id_q;

  ////////////////////
  // enable check
  ////////////////////

  // user mode: u_ie or a secure line gets through
  // machine mode: only m_ie matters
  assign irq_en_ext = ((u_ie_i | irq_sec_i) & (priv_lvl_i == PRIV_U)) |
                      (m_ie_i & (priv_lvl_i == PRIV_M));

  // same check on the registered request, csr state may have moved since
  assign irq_en_int = ((u_ie_i | irq_sec_q) & (priv_lvl_i == PRIV_U)) |
                      (m_ie_i & (priv_lvl_i == PRIV_M));

  // sample the request until it is acked, then hold it for the core
  assign sample_en = (state_q != EXC_ACK);

  assign ctrl.irq_id  = irq_id_q;
  assign ctrl.irq_sec = irq_sec_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= EXC_IDLE;
      irq_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (sample_en)
        irq_q <= irq_i;
    end
  end

  // payload copy of the winner, frozen from the ack onward
  always_ff @(posedge clk)
  begin
    if (sample_en)
    begin
      irq_sec_q <= irq_sec_i;
      irq_id_q  <= irq_id_i;
    end
  end

  ////////////////////
  // request fsm
  ////////////////////

  always_comb
  begin
    state_d      = state_q;
    ctrl.irq_req = 1'b0;
    unique case (state_q)
      EXC_IDLE:
      begin
        if (irq_i && irq_en_ext)
          state_d = EXC_PENDING;
      end
      EXC_PENDING:
      begin
        // keep asking only while still enabled
        if (irq_q && irq_en_int)
        begin
          ctrl.irq_req = 1'b1;
          if (ctrl.ack)
            state_d = EXC_ACK;
        end
        else if (ctrl.ack)
        begin
          // core acked a request that went away, drop it
          state_d = EXC_IDLE;
        end
      end
      EXC_ACK:
      begin
        if (ctrl.done)
          state_d = EXC_IDLE;
      end
      default:
      begin
        state_d = EXC_IDLE;
      end
    endcase
  end

endmodule

//--- design/irq_arbiter.sv
`timescale 1ns/1ns

`include "irq_defines.svh"

module irq_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`IRQ_NUM-1:0]  irq_lines_i,
  input  logic [`IRQ_NUM-1:0]  sec_mask_i,
  output logic                 irq_valid_o,
  output logic [`IRQ_ID_W-1:0] irq_id_o,
  output logic                 irq_sec_o
);

  logic                 any_d;
  logic [`IRQ_ID_W-1:0] id_d;
  logic                 sec_d;

  // any line active at all
  assign any_d = |irq_lines_i;

  // fixed priority, lowest index wins
  // scan from the top so the last hit is the lowest line
  always_comb
  begin
    id_d  = '0;
    sec_d = 1'b0;
    for (int i = `IRQ_NUM - 1; i >= 0; i--)
    begin
      if (irq_lines_i[i])
      begin
        id_d  = i[`IRQ_ID_W-1:0];
        sec_d = sec_mask_i[i];
      end
    end
  end

  // valid flag
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      irq_valid_o <= 1'b0;
    else
      irq_valid_o <= any_d;
  end

  // winner id and its secure bit, only meaningful with valid
  always_ff @(posedge clk)
  begin
    irq_id_o  <= id_d;
    irq_sec_o <= sec_d;
  end

endmodule

//--- design/exc_ctrl_if.sv
`timescale 1ns/1ns

`include "irq_defines.svh"

interface exc_ctrl_if;

  // request from the exception controller, a level
  logic                 irq_req;
  logic                 irq_sec;
  logic [`IRQ_ID_W-1:0] irq_id;

  // answer from the core controller, single-cycle pulses
  logic                 ack;
  logic                 done;

  // exception controller side
  modport exc (
    output irq_req, irq_sec, irq_id,
    input  ack, done
  );

  // core controller side
  modport core (
    input  irq_req, irq_sec, irq_id,
    output ack, done
  );

endinterface

//--- design/irq_pkg.sv
package irq_pkg;

  ////////////////////
  // privilege levels
  ////////////////////

  // encodings follow the riscv mstatus.mpp field
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  ////////////////////
  // fsm states
  ////////////////////

  // exception controller request side
  typedef enum logic [1:0] {
    EXC_IDLE,
    EXC_PENDING,
    EXC_ACK
  } exc_state_e;

  // core-side trap sequencer
  typedef enum logic [2:0] {
    SEQ_RUN,
    SEQ_WAIT,
    SEQ_ACK,
    SEQ_ENTER,
    SEQ_HANDLER
  } seq_state_e;

endpackage

//--- design/irq_defines.svh
`ifndef IRQ_DEFINES_SVH
`define IRQ_DEFINES_SVH

////////////////////
// interrupt sizing
////////////////////

// number of level-triggered interrupt lines
`define IRQ_NUM 32

// width of an interrupt id, log2 of IRQ_NUM
`define IRQ_ID_W 5

// sequencer cycles between seeing a request and the ack
// models the pipeline drain, must be at least 1
`define ACK_DELAY 2

`endif
